//--- bridge_cfg_pkg.sv
// Bridge sizing: flit widths, credit budget and the matching data types, imported by the RTL

package bridge_cfg_pkg;

  //////////////////////////////////////////////////
  // Flit widths
  //////////////////////////////////////////////////

  localparam int NARROW_W = 32;
  localparam int WIDE_W   = 64;

  //////////////////////////////////////////////////
  // Credit flow control
  //////////////////////////////////////////////////

  // Receive queue depth, also the credits each sender starts with
  localparam int NUM_CREDITS       = 8;
  localparam int CREDIT_W          = 4;
  // Owed credits that force a packet without data
  localparam int FORCE_SEND_THRESH = 4;

  typedef logic [NARROW_W-1:0] narrow_data_t;
  typedef logic [WIDE_W-1:0]   wide_data_t;
  typedef logic [CREDIT_W-1:0] credit_t;

endpackage

//--- bridge_ctrl.sv
// Link control: picks narrow or wide traffic, piggybacks owed credits and decodes received packets
`timescale 1ns/100ps

module bridge_ctrl
  import bridge_cfg_pkg::*;
  import link_pkt_pkg::*;
(
  credit_chan_if.ctrl narrow_ch,
  credit_chan_if.ctrl wide_ch,

  input  logic         clk_i,
  input  logic         arst_n_i,

  output logic         pkt_valid_o,
  output link_word_t   pkt_o,
  input  logic         pkt_ready_i,

  input  logic         axis_in_tvalid_i,
  input  link_data_t   axis_in_tdata_i,
  input  link_user_t   axis_in_tuser_i,
  output logic         axis_in_tready_o,

  output logic         nq_valid_o,
  output narrow_data_t nq_data_o,
  input  logic         nq_ready_i,
  output logic         wq_valid_o,
  output wide_data_t   wq_data_o,
  input  logic         wq_ready_i
);

  sel_state_e state_q, state_d;
  chan_id_t   tx_data_hdr, tx_cred_hdr;
  wide_data_t tx_data;
  logic       tx_dvalid;
  credit_t    tx_credits;
  chan_id_t   rx_data_hdr, rx_cred_hdr;
  wide_data_t rx_payload;
  logic       rx_dvalid;
  credit_t    rx_credits;
  logic       rx_take;

  //////////////////////////////////////////////////
  // Transmit: channel select
  //////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    narrow_ch.ready = 1'b0;
    wide_ch.ready   = 1'b0;
    case (state_q)
      SEL_WIDE: begin
        pkt_valid_o   = wide_ch.valid;
        wide_ch.ready = pkt_ready_i;
        tx_data_hdr   = CHAN_WIDE;
        tx_data       = wide_ch.data;
        tx_dvalid     = ~wide_ch.cred_only;
        // Return to narrow once no wide packet is left hanging
        if ((!wide_ch.valid || pkt_ready_i) && narrow_ch.valid) begin
          state_d = SEL_NARROW;
        end
      end
      default: begin
        pkt_valid_o     = narrow_ch.valid;
        narrow_ch.ready = pkt_ready_i;
        tx_data_hdr     = CHAN_NARROW;
        tx_data         = narrow_ch.data;
        tx_dvalid       = ~narrow_ch.cred_only;
        if (wide_ch.valid && !narrow_ch.valid) begin
          state_d = SEL_WIDE;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= SEL_NARROW;
    end else begin
      state_q <= state_d;
    end
  end

  // Larger owed count rides along, narrow on a tie
  assign tx_cred_hdr = (wide_ch.owed > narrow_ch.owed) ? CHAN_WIDE : CHAN_NARROW;
  assign tx_credits  = (tx_cred_hdr == CHAN_WIDE) ? wide_ch.owed : narrow_ch.owed;

  assign narrow_ch.cred_sel = pkt_valid_o & pkt_ready_i & (tx_cred_hdr == CHAN_NARROW);
  assign wide_ch.cred_sel   = pkt_valid_o & pkt_ready_i & (tx_cred_hdr == CHAN_WIDE);

  assign pkt_o = {tx_dvalid, tx_cred_hdr, tx_credits, tx_data, tx_data_hdr};

  //////////////////////////////////////////////////
  // Receive: decode by headers
  //////////////////////////////////////////////////

  assign {rx_payload, rx_data_hdr}            = axis_in_tdata_i;
  assign {rx_dvalid, rx_cred_hdr, rx_credits} = axis_in_tuser_i;

  assign nq_valid_o = axis_in_tvalid_i & rx_dvalid & (rx_data_hdr == CHAN_NARROW);
  assign wq_valid_o = axis_in_tvalid_i & rx_dvalid & (rx_data_hdr == CHAN_WIDE);
  assign nq_data_o  = rx_payload[NARROW_W-1:0];
  assign wq_data_o  = rx_payload;

  // Credit-only packets are always taken
  assign axis_in_tready_o = (nq_valid_o & nq_ready_i) | (wq_valid_o & wq_ready_i) |
                            (axis_in_tvalid_i & ~rx_dvalid);
  assign rx_take = axis_in_tvalid_i & axis_in_tready_o;

  assign narrow_ch.cred_in_valid = rx_take & (rx_cred_hdr == CHAN_NARROW);
  assign wide_ch.cred_in_valid   = rx_take & (rx_cred_hdr == CHAN_WIDE);
  assign narrow_ch.cred_in       = rx_credits;
  assign wide_ch.cred_in         = rx_credits;

endmodule

//--- credit_chan_if.sv
// Handshake and credit signals of one virtual channel, between its credit counter and the control
`timescale 1ns/100ps

interface credit_chan_if
  import bridge_cfg_pkg::*;
();

  // Channel side
  logic       valid;
  wide_data_t data;
  logic       cred_only;
  credit_t    owed;

  // Control side
  logic       ready;
  // High when this channel's owed credits leave on the packet taken this cycle
  logic       cred_sel;
  logic       cred_in_valid;
  credit_t    cred_in;

  modport chan (
    output valid, data, cred_only, owed,
    input  ready, cred_sel, cred_in_valid, cred_in
  );

  modport ctrl (
    input  valid, data, cred_only, owed,
    output ready, cred_sel, cred_in_valid, cred_in
  );

endinterface

//--- credit_tx.sv
// Transmit credit counter of one channel: holds a flit until the remote queue has room for it
`timescale 1ns/100ps

module credit_tx
  import bridge_cfg_pkg::*;
#(
  parameter int WIDTH = NARROW_W
) (
  input  logic             clk_i,
  input  logic             arst_n_i,

  input  logic             in_valid_i,
  input  logic [WIDTH-1:0] in_data_i,
  output logic             in_ready_o,

  // One flit left the local receive queue
  input  logic             rx_pop_i,

  credit_chan_if.chan      chan
);

  logic             rst_done_q;
  logic             hold_valid_q;
  logic [WIDTH-1:0] hold_data_q;
  credit_t          avail_q, avail_d;
  credit_t          owed_q, owed_d;
  logic             accept;
  logic             data_xfer;

  //////////////////////////////////////////////////
  // Input side
  //////////////////////////////////////////////////

  // No input during the first cycle out of reset
  assign in_ready_o = rst_done_q & ~hold_valid_q & (avail_q != '0);
  assign accept     = in_valid_i & in_ready_o;
  assign data_xfer  = hold_valid_q & chan.valid & chan.ready;

  // Payload register, loaded only when empty
  always_ff @(posedge clk_i) begin
    if (accept) begin
      hold_data_q <= in_data_i;
    end
  end

  //////////////////////////////////////////////////
  // Credit counters
  //////////////////////////////////////////////////

  always_comb begin
    avail_d = avail_q;
    if (accept) begin
      avail_d = avail_d - 1'b1;
    end
    if (chan.cred_in_valid) begin
      avail_d = avail_d + chan.cred_in;
    end
  end

  always_comb begin
    owed_d = owed_q;
    // Remove what was presented, pops of this cycle still count
    if (chan.cred_sel) begin
      owed_d = owed_d - owed_q;
    end
    if (rx_pop_i) begin
      owed_d = owed_d + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rst_done_q   <= 1'b0;
      hold_valid_q <= 1'b0;
      avail_q      <= credit_t'(NUM_CREDITS);
      owed_q       <= '0;
    end else begin
      rst_done_q <= 1'b1;
      if (accept) begin
        hold_valid_q <= 1'b1;
      end else if (data_xfer) begin
        hold_valid_q <= 1'b0;
      end
      avail_q <= avail_d;
      owed_q  <= owed_d;
    end
  end

  // Credit-only request when idle and enough credits are owed
  assign chan.cred_only = ~hold_valid_q & (owed_q >= credit_t'(FORCE_SEND_THRESH));
  assign chan.valid     = hold_valid_q | chan.cred_only;
  assign chan.data      = wide_data_t'(hold_data_q);
  assign chan.owed      = owed_q;

endmodule

//--- flit_fifo.sv
// Valid/ready FIFO of configurable width and depth, for the receive queues and the link output
`timescale 1ns/100ps

module flit_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 8
) (
  input  logic             clk_i,
  input  logic             arst_n_i,

  input  logic             wr_valid_i,
  input  logic [WIDTH-1:0] wr_data_i,
  output logic             wr_ready_o,

  output logic             rd_valid_o,
  output logic [WIDTH-1:0] rd_data_o,
  input  logic             rd_ready_i
);

  logic [WIDTH-1:0]           mem_q [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr_q, rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0] count_q;
  logic                       push, pop;

  assign wr_ready_o = (int'(count_q) != DEPTH);
  assign rd_valid_o = (count_q != '0);
  assign rd_data_o  = mem_q[rd_ptr_q];

  assign push = wr_valid_i & wr_ready_o;
  assign pop  = rd_valid_o & rd_ready_i;

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= wr_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (int'(wr_ptr_q) == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (int'(rd_ptr_q) == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      // Fill count, unchanged on simultaneous push and pop
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

//--- link_pkt_pkg.sv
// Serial link packet format and channel select states, shared by the control path and the top level

package link_pkt_pkg;

  import bridge_cfg_pkg::*;

  // Channel header, used both for the data and for the credits
  typedef logic [0:0] chan_id_t;

  localparam chan_id_t CHAN_NARROW = 1'b0;
  localparam chan_id_t CHAN_WIDE   = 1'b1;

  //////////////////////////////////////////////////
  // Link fields
  //////////////////////////////////////////////////

  // Payload above the data header in bit 0
  localparam int LINK_DATA_W = WIDE_W + 1;
  // data_valid, credit header, credits from the MSB down
  localparam int LINK_USER_W = 1 + 1 + CREDIT_W;

  typedef logic [LINK_DATA_W-1:0]             link_data_t;
  typedef logic [LINK_USER_W-1:0]             link_user_t;
  typedef logic [LINK_USER_W+LINK_DATA_W-1:0] link_word_t;

  typedef enum logic {
    SEL_NARROW,
    SEL_WIDE
  } sel_state_e;

endpackage

//--- noc_link_bridge.sv
// Top level of the two-channel credit bridge, connecting NoC flit ports to one serial link
`timescale 1ns/100ps

module noc_link_bridge
  import bridge_cfg_pkg::*;
  import link_pkt_pkg::*;
(
  input  logic         clk_i,
  input  logic         arst_n_i,

  input  logic         narrow_in_valid_i,
  input  narrow_data_t narrow_in_data_i,
  output logic         narrow_in_ready_o,
  input  logic         wide_in_valid_i,
  input  wide_data_t   wide_in_data_i,
  output logic         wide_in_ready_o,

  output logic         narrow_out_valid_o,
  output narrow_data_t narrow_out_data_o,
  input  logic         narrow_out_ready_i,
  output logic         wide_out_valid_o,
  output wide_data_t   wide_out_data_o,
  input  logic         wide_out_ready_i,

  output logic         axis_out_tvalid_o,
  output link_data_t   axis_out_tdata_o,
  output link_user_t   axis_out_tuser_o,
  input  logic         axis_out_tready_i,

  input  logic         axis_in_tvalid_i,
  input  link_data_t   axis_in_tdata_i,
  input  link_user_t   axis_in_tuser_i,
  output logic         axis_in_tready_o
);

  logic         pkt_valid, pkt_ready;
  link_word_t   pkt_word;
  logic         nq_valid, nq_ready;
  narrow_data_t nq_data;
  logic         wq_valid, wq_ready;
  wide_data_t   wq_data;

  credit_chan_if narrow_if ();
  credit_chan_if wide_if ();

  //////////////////////////////////////////////////
  // Transmit credit counters
  //////////////////////////////////////////////////

  // Credits come back as flits leave the receive queues
  credit_tx #(.WIDTH(NARROW_W)) u_narrow_tx (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .in_valid_i(narrow_in_valid_i), .in_data_i(narrow_in_data_i),
    .in_ready_o(narrow_in_ready_o),
    .rx_pop_i(narrow_out_valid_o & narrow_out_ready_i),
    .chan(narrow_if.chan)
  );

  credit_tx #(.WIDTH(WIDE_W)) u_wide_tx (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .in_valid_i(wide_in_valid_i), .in_data_i(wide_in_data_i),
    .in_ready_o(wide_in_ready_o),
    .rx_pop_i(wide_out_valid_o & wide_out_ready_i),
    .chan(wide_if.chan)
  );

  bridge_ctrl u_ctrl (
    .narrow_ch(narrow_if.ctrl), .wide_ch(wide_if.ctrl),
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .pkt_valid_o(pkt_valid), .pkt_o(pkt_word), .pkt_ready_i(pkt_ready),
    .axis_in_tvalid_i(axis_in_tvalid_i), .axis_in_tdata_i(axis_in_tdata_i),
    .axis_in_tuser_i(axis_in_tuser_i), .axis_in_tready_o(axis_in_tready_o),
    .nq_valid_o(nq_valid), .nq_data_o(nq_data), .nq_ready_i(nq_ready),
    .wq_valid_o(wq_valid), .wq_data_o(wq_data), .wq_ready_i(wq_ready)
  );

  //////////////////////////////////////////////////
  // Queues
  //////////////////////////////////////////////////

  // Keeps axis_out stable under back-pressure
  flit_fifo #(.WIDTH(LINK_USER_W + LINK_DATA_W), .DEPTH(2)) u_link_out_fifo (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .wr_valid_i(pkt_valid), .wr_data_i(pkt_word), .wr_ready_o(pkt_ready),
    .rd_valid_o(axis_out_tvalid_o), .rd_data_o({axis_out_tuser_o, axis_out_tdata_o}),
    .rd_ready_i(axis_out_tready_i)
  );

  flit_fifo #(.WIDTH(NARROW_W), .DEPTH(NUM_CREDITS)) u_narrow_rx_fifo (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .wr_valid_i(nq_valid), .wr_data_i(nq_data), .wr_ready_o(nq_ready),
    .rd_valid_o(narrow_out_valid_o), .rd_data_o(narrow_out_data_o),
    .rd_ready_i(narrow_out_ready_i)
  );

  flit_fifo #(.WIDTH(WIDE_W), .DEPTH(NUM_CREDITS)) u_wide_rx_fifo (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .wr_valid_i(wq_valid), .wr_data_i(wq_data), .wr_ready_o(wq_ready),
    .rd_valid_o(wide_out_valid_o), .rd_data_o(wide_out_data_o),
    .rd_ready_i(wide_out_ready_i)
  );

endmodule

//--- noc_link_bridge_checker.sv
// Link and reset assertions for the bridge top level, attached to it by a bind in the testbench
`timescale 1ns/100ps

module noc_link_bridge_checker
  import bridge_cfg_pkg::*;
  import link_pkt_pkg::*;
(
  input logic       clk_i,
  input logic       arst_n_i,
  input logic       link_valid_i,
  input logic       link_ready_i,
  input link_data_t link_data_i,
  input link_user_t link_user_i,
  input logic       narrow_valid_i,
  input logic       wide_valid_i
);

  // Stalled packet stays put until taken
  a_link_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    link_valid_i && !link_ready_i |=>
      link_valid_i && $stable(link_data_i) && $stable(link_user_i))
    else $error("link packet changed while stalled");

  // Packet without data must return credits
  a_cred_only_nonzero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    link_valid_i && !link_user_i[LINK_USER_W-1] |-> link_user_i[CREDIT_W-1:0] != '0)
    else $error("link packet carries neither data nor credits");

  a_reset_quiet: assert property (@(posedge clk_i)
    !arst_n_i |-> !narrow_valid_i && !wide_valid_i && !link_valid_i)
    else $error("output valid high during reset");

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line in its output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_noc_link_bridge -f sources.f -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -x "Verification passed" > /dev/null \
  && echo "run.sh: simulation ok" \
  || { echo "run.sh: simulation did not pass" >&2; exit 1; }

//--- sources.f
bridge_cfg_pkg.sv
link_pkt_pkg.sv
credit_chan_if.sv
credit_tx.sv
flit_fifo.sv
bridge_ctrl.sv
noc_link_bridge.sv
noc_link_bridge_checker.sv
tb_noc_link_bridge.sv

//--- tb_noc_link_bridge.sv
// Testbench for the link bridge with the link looped back under random stalls and a reference model
`timescale 1ns/100ps

module tb_noc_link_bridge
  import bridge_cfg_pkg::*;
  import link_pkt_pkg::*;
();

  localparam int HALF_PERIOD = 10;
  localparam int TIMEOUT     = 3000;

  logic         clk_i;
  logic         arst_n_i;
  logic         narrow_in_valid, narrow_in_ready, wide_in_valid, wide_in_ready;
  narrow_data_t narrow_in_data, narrow_out_data;
  wide_data_t   wide_in_data, wide_out_data;
  logic         narrow_out_valid, narrow_out_ready, wide_out_valid, wide_out_ready;
  logic         out_tvalid, out_tready, in_tvalid, in_tready, link_stall;
  link_data_t   link_tdata;
  link_user_t   link_tuser;

  // Stimulus knobs in percent
  int unsigned  narrow_pct, wide_pct, narrow_rdy_pct, wide_rdy_pct, stall_pct;

  // Model state
  narrow_data_t link_n[$], out_n[$];
  wide_data_t   link_w[$], out_w[$];
  logic         n_taken, w_taken;
  int unsigned  n_accepted, w_accepted, cred_only_seen;
  // Output pops not yet returned as credits on the link
  int unsigned  n_owed, w_owed;
  int unsigned  err_count, tests_run, tests_failed;

  // The DUT talks to itself through a random stall
  assign in_tvalid  = out_tvalid & ~link_stall;
  assign out_tready = in_tready & ~link_stall;

  noc_link_bridge u_dut (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .narrow_in_valid_i(narrow_in_valid), .narrow_in_data_i(narrow_in_data),
    .narrow_in_ready_o(narrow_in_ready),
    .wide_in_valid_i(wide_in_valid), .wide_in_data_i(wide_in_data),
    .wide_in_ready_o(wide_in_ready),
    .narrow_out_valid_o(narrow_out_valid), .narrow_out_data_o(narrow_out_data),
    .narrow_out_ready_i(narrow_out_ready),
    .wide_out_valid_o(wide_out_valid), .wide_out_data_o(wide_out_data),
    .wide_out_ready_i(wide_out_ready),
    .axis_out_tvalid_o(out_tvalid), .axis_out_tdata_o(link_tdata),
    .axis_out_tuser_o(link_tuser), .axis_out_tready_i(out_tready),
    .axis_in_tvalid_i(in_tvalid), .axis_in_tdata_i(link_tdata),
    .axis_in_tuser_i(link_tuser), .axis_in_tready_o(in_tready)
  );

  bind noc_link_bridge noc_link_bridge_checker u_checker (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .link_valid_i(axis_out_tvalid_o), .link_ready_i(axis_out_tready_i),
    .link_data_i(axis_out_tdata_o), .link_user_i(axis_out_tuser_o),
    .narrow_valid_i(narrow_out_valid_o), .wide_valid_i(wide_out_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #HALF_PERIOD clk_i = ~clk_i;
  end

  task automatic value_error(input string msg);
    $display("error at %0d ns: %s", $time, msg);
    err_count++;
  endtask

  task automatic note_failure(input string msg);
    $display("%s (at %0d ns)", msg, $time);
    err_count++;
  endtask

  task automatic timed_out(input string what);
    $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT);
    err_count++;
  endtask

  //////////////////////////////////////////////////
  // Model sampled on the rising edge
  //////////////////////////////////////////////////

  // A packet never returns more credits than its channel has popped
  task automatic take_credits(inout int unsigned owed, input credit_t credits,
                              input string chan);
    if (credits > owed) begin
      value_error($sformatf("%s credits %0d on the link, only %0d owed", chan, credits, owed));
      owed = 0;
    end else begin
      owed -= credits;
    end
  endtask

  task automatic check_link_packet();
    narrow_data_t n_exp;
    wide_data_t   w_exp;
    wide_data_t   payload;
    credit_t      credits;
    payload = link_tdata[LINK_DATA_W-1:1];
    credits = link_tuser[CREDIT_W-1:0];
    if (link_tuser[LINK_USER_W-2] == CHAN_NARROW) begin
      take_credits(n_owed, credits, "narrow");
    end else begin
      take_credits(w_owed, credits, "wide");
    end
    if (!link_tuser[LINK_USER_W-1]) begin
      cred_only_seen++;
      if (credits < credit_t'(FORCE_SEND_THRESH)) begin
        value_error($sformatf("credit-only packet with %0d credits, expected at least %0d",
                              credits, FORCE_SEND_THRESH));
      end
    end else if (link_tdata[0] == CHAN_NARROW) begin
      if (link_n.size() == 0) begin
        note_failure("narrow header on the link with no narrow flit pending");
      end else begin
        n_exp = link_n.pop_front();
        if (payload != wide_data_t'(n_exp)) begin
          value_error($sformatf("narrow link payload %h, expected %h", payload, n_exp));
        end
      end
    end else if (link_w.size() == 0) begin
      note_failure("wide header on the link with no wide flit pending");
    end else begin
      w_exp = link_w.pop_front();
      if (payload != w_exp) begin
        value_error($sformatf("wide link payload %h, expected %h", payload, w_exp));
      end
    end
  endtask

  always @(posedge clk_i) begin : model
    narrow_data_t n_exp;
    wide_data_t   w_exp;
    n_taken = narrow_in_valid & narrow_in_ready;
    w_taken = wide_in_valid & wide_in_ready;
    if (n_taken) begin
      link_n.push_back(narrow_in_data);
      out_n.push_back(narrow_in_data);
      n_accepted++;
    end
    if (w_taken) begin
      link_w.push_back(wide_in_data);
      out_w.push_back(wide_in_data);
      w_accepted++;
    end
    if (out_tvalid && out_tready) begin
      check_link_packet();
    end
    if (narrow_out_valid && narrow_out_ready) begin
      n_owed++;
      if (out_n.size() == 0) begin
        note_failure("narrow output gave a flit that was never sent");
      end else begin
        n_exp = out_n.pop_front();
        if (narrow_out_data != n_exp) begin
          value_error($sformatf("narrow flit %h, expected %h", narrow_out_data, n_exp));
        end
      end
    end
    if (wide_out_valid && wide_out_ready) begin
      w_owed++;
      if (out_w.size() == 0) begin
        note_failure("wide output gave a flit that was never sent");
      end else begin
        w_exp = out_w.pop_front();
        if (wide_out_data != w_exp) begin
          value_error($sformatf("wide flit %h, expected %h", wide_out_data, w_exp));
        end
      end
    end
    // Credits bound the flits in flight per channel
    if (out_n.size() > NUM_CREDITS || out_w.size() > NUM_CREDITS) begin
      note_failure("more flits in flight than the receive queue can hold");
    end
  end

  //////////////////////////////////////////////////
  // Stimulus and test sequence
  //////////////////////////////////////////////////

  // Valid stays up with the same data until taken
  task automatic drive_cycle();
    @(negedge clk_i);
    if (!narrow_in_valid || n_taken) begin
      narrow_in_valid = ($urandom_range(99) < narrow_pct);
      narrow_in_data  = $urandom;
    end
    if (!wide_in_valid || w_taken) begin
      wide_in_valid = ($urandom_range(99) < wide_pct);
      wide_in_data  = {$urandom, $urandom};
    end
    narrow_out_ready = ($urandom_range(99) < narrow_rdy_pct);
    wide_out_ready   = ($urandom_range(99) < wide_rdy_pct);
    link_stall       = ($urandom_range(99) < stall_pct);
  endtask

  task automatic run_until_accepted(input int unsigned n_target, input int unsigned w_target,
                                    input string what);
    int cycles;
    cycles = 0;
    while ((n_accepted < n_target || w_accepted < w_target) && cycles < TIMEOUT) begin
      drive_cycle();
      cycles++;
    end
    if (n_accepted < n_target || w_accepted < w_target) begin
      timed_out(what);
    end
  endtask

  task automatic wait_drained(input string what);
    int cycles;
    cycles = 0;
    while ((out_n.size() != 0 || out_w.size() != 0) && cycles < TIMEOUT) begin
      drive_cycle();
      cycles++;
    end
    if (out_n.size() != 0 || out_w.size() != 0) begin
      timed_out(what);
    end
  endtask

  task automatic report_test(input string name, input int unsigned errs_before);
    tests_run++;
    if (err_count == errs_before) begin
      $display("test %0d, %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d, %s: FAILED, %0d errors", tests_run, name, err_count - errs_before);
    end
  endtask

  // Random traffic up to the count and then a drain with the inputs stopped
  task automatic stream_test(input string name, input int unsigned n_pct,
                             input int unsigned w_pct, input int unsigned rdy,
                             input int unsigned stall, input int unsigned count);
    int unsigned errs;
    errs           = err_count;
    narrow_pct     = n_pct;
    wide_pct       = w_pct;
    narrow_rdy_pct = rdy;
    wide_rdy_pct   = rdy;
    stall_pct      = stall;
    run_until_accepted(n_accepted + (n_pct != 0 ? count : 0),
                       w_accepted + (w_pct != 0 ? count : 0), {name, " input"});
    narrow_pct = 0;
    wide_pct   = 0;
    wait_drained({name, " drain"});
    report_test(name, errs);
  endtask

  initial begin
    int unsigned errs, n_base, c_base, stuck;
    int          cycles;
    void'($urandom(72856));
    arst_n_i         = 1'b1;
    narrow_in_valid  = 1'b0;
    narrow_in_data   = '0;
    wide_in_valid    = 1'b0;
    wide_in_data     = '0;
    narrow_out_ready = 1'b0;
    wide_out_ready   = 1'b0;
    link_stall       = 1'b0;
    n_taken          = 1'b0;
    w_taken          = 1'b0;
    {narrow_pct, wide_pct, narrow_rdy_pct, wide_rdy_pct, stall_pct} = '0;
    {n_accepted, w_accepted, cred_only_seen} = '0;
    {n_owed, w_owed} = '0;
    {err_count, tests_run, tests_failed} = '0;

    // Test 1 checks quiet outputs in reset and in the first cycle after it
    errs = err_count;
    #1 arst_n_i = 1'b0;
    repeat (4) begin
      @(negedge clk_i);
      if (narrow_out_valid || wide_out_valid || out_tvalid || narrow_in_ready || wide_in_ready)
        note_failure("a valid or ready output is high during reset");
    end
    arst_n_i = 1'b1;
    #1;
    if (narrow_out_valid || wide_out_valid || out_tvalid || narrow_in_ready || wide_in_ready)
      note_failure("a valid or ready output is high right after reset");
    report_test("reset outputs", errs);

    stream_test("narrow in order", 70, 0, 100, 0, 40);
    stream_test("wide in order", 0, 70, 100, 0, 40);
    stream_test("mixed with stalls", 50, 50, 70, 30, 60);

    // Test 5 holds the narrow output so the input stops once credits run out
    errs = err_count;
    narrow_pct     = 100;
    narrow_rdy_pct = 0;
    wide_rdy_pct   = 100;
    stuck          = 0;
    cycles         = 0;
    while (stuck < 20 && cycles < TIMEOUT) begin
      drive_cycle();
      stuck = (narrow_in_valid && !narrow_in_ready) ? stuck + 1 : 0;
      cycles++;
    end
    if (stuck < 20) begin
      timed_out("narrow input stall behind the held output");
    end
    n_base         = n_accepted;
    narrow_rdy_pct = 100;
    run_until_accepted(n_base + 4, w_accepted, "narrow input accepting after release");
    narrow_pct = 0;
    wait_drained("held narrow flits");
    report_test("narrow credit limit", errs);

    // Test 6 uses a burst of pops with no data to carry them
    errs         = err_count;
    c_base       = cred_only_seen;
    wide_pct     = 100;
    wide_rdy_pct = 0;
    cycles       = 0;
    while (out_w.size() < 4 && cycles < TIMEOUT) begin
      drive_cycle();
      cycles++;
    end
    if (out_w.size() < 4) begin
      timed_out("wide flits queued at the held output");
    end
    wide_pct = 0;
    cycles   = 0;
    while ((wide_in_valid || link_w.size() != 0) && cycles < TIMEOUT) begin
      drive_cycle();
      cycles++;
    end
    if (wide_in_valid || link_w.size() != 0) begin
      timed_out("wide flits crossing the link");
    end
    wide_rdy_pct = 100;
    wait_drained("wide flits after release");
    cycles = 0;
    while (cred_only_seen == c_base && cycles < TIMEOUT) begin
      drive_cycle();
      cycles++;
    end
    if (cred_only_seen == c_base) begin
      timed_out("a credit-only packet on the link");
    end
    report_test("credit-only packets", errs);

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
